//--- tb.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/mul_unit.sv
verilog/mul_apb_regs.sv
verilog/mul_top.sv
verif/tb_clk_gen.sv
verif/tb_mul_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mul_top
FILELIST   := tb.f
FLAGS      := --timing --assert --timescale 1ns/100ps
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Errors found
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_mul_top.sv
`include "mul_settings.svh"

module tb_mul_top import mul_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Upper bounds for the polling loops
  localparam int RESET_WAIT = 20;
  localparam int POLL_LIMIT = 50;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  int errors;
  int checks;
  // Set only for launches into an empty slot, arms the latency checks
  logic timed_launch;
  logic ctrl_acc;
  logic slot_full;

  logic [31:0] corners [4] = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF};

  tb_clk_gen u_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mul_top u_mul_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  ////////////////////////////////////////
  // Latency and protocol checks
  ////////////////////////////////////////

  assign ctrl_acc  = apb_req.psel && apb_req.penable && apb_req.pwrite &&
                     (apb_req.paddr == `MUL_REG_CTRL);
  // Slot flag probed inside the register block for edge-exact timing
  assign slot_full = u_mul_top.u_mul_apb_regs.full_q;

  // MUL lands in the slot on the second edge after the CTRL write
  a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_acc && timed_launch && !apb_req.pwdata[0])
      |-> !slot_full ##1 !slot_full ##1 slot_full)
    else begin
      errors++;
      $display("MUL result did not reach the slot exactly two edges after CTRL write");
    end

  // MULH walks four partial products, slot fills on the fifth edge
  a_mulh_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_acc && timed_launch && apb_req.pwdata[0])
      |-> !slot_full ##1 !slot_full ##1 !slot_full ##1 !slot_full ##1 !slot_full
          ##1 slot_full)
    else begin
      errors++;
      $display("MULH result did not reach the slot exactly five edges after CTRL write");
    end

  // Zero wait state slave
  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel |-> apb_rsp.pready)
    else begin
      errors++;
      $display("APB pready dropped during an access");
    end

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // 64 bit product with each operand extended per its signedness bit
  function automatic logic [31:0] product_ref(mul_opcode_e op, logic [1:0] ss,
                                              logic [31:0] a, logic [31:0] b);
    logic signed [64:0] ext_a;
    logic signed [64:0] ext_b;
    logic signed [64:0] prod;
    ext_a = ss[0] ? {{33{a[31]}}, a} : {33'd0, a};
    ext_b = ss[1] ? {{33{b[31]}}, b} : {33'd0, b};
    prod  = ext_a * ext_b;
    return (op == MUL_H) ? prod[63:32] : prod[31:0];
  endfunction

  task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s expected=%h actual=%h", name, exp, act);
    end
  endtask

  // Setup phase then access phase, inputs change 1 ns after the edge
  task automatic apb_access(logic wr, logic [`MUL_ADDR_W-1:0] addr, logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    // Response is settled mid cycle
    @(negedge clk);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic ctrl_write(mul_opcode_e op, logic [1:0] ss, logic timed,
                            output logic slverr);
    logic [31:0] unused;
    timed_launch = timed;
    apb_access(1'b1, `MUL_REG_CTRL, {29'd0, ss, op}, unused, slverr);
    timed_launch = 1'b0;
  endtask

  task automatic load_operands(logic [31:0] a, logic [31:0] b);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, `MUL_REG_OP_A, a, rdata, err);
    apb_access(1'b1, `MUL_REG_OP_B, b, rdata, err);
  endtask

  // Poll STATUS until the slot holds a result
  task automatic wait_full(string name);
    logic [31:0] status;
    logic        err;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      apb_access(1'b0, `MUL_REG_STATUS, '0, status, err);
      polls++;
    end
    if (!status[1]) begin
      errors++;
      $display("Timeout waiting for the result slot to fill in %s", name);
    end
  endtask

  task automatic run_op(string name, mul_opcode_e op, logic [1:0] ss,
                        logic [31:0] a, logic [31:0] b);
    logic [31:0] rdata;
    logic        err;
    load_operands(a, b);
    ctrl_write(op, ss, 1'b1, err);
    compare({name, "_launch_err"}, 32'd0, {31'd0, err});
    wait_full(name);
    apb_access(1'b0, `MUL_REG_RESULT, '0, rdata, err);
    compare(name, product_ref(op, ss, a, b), rdata);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] a2;
    logic [31:0] b2;
    int          cyc;

    apb_req      = '0;
    timed_launch = 1'b0;
    errors       = 0;
    checks       = 0;
    void'($urandom(62));

    cyc = 0;
    while (rst_n !== 1'b1 && cyc < RESET_WAIT) begin
      @(posedge clk);
      cyc++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Timeout waiting for reset release");
    end

    // Reset values and plain register access
    apb_access(1'b0, `MUL_REG_STATUS, '0, rdata, err);
    compare("reset_status", 32'd0, rdata);
    apb_access(1'b0, `MUL_REG_RESULT, '0, rdata, err);
    compare("reset_result", 32'd0, rdata);
    a = $urandom;
    b = $urandom;
    load_operands(a, b);
    apb_access(1'b0, `MUL_REG_OP_A, '0, rdata, err);
    compare("op_a_readback", a, rdata);
    apb_access(1'b0, `MUL_REG_OP_B, '0, rdata, err);
    compare("op_b_readback", b, rdata);
    apb_access(1'b0, 5'h14, '0, rdata, err);
    compare("unmapped_rd_err", 32'd1, {31'd0, err});
    compare("unmapped_rd_data", 32'd0, rdata);
    apb_access(1'b1, 5'h1C, 32'hA5A5_A5A5, rdata, err);
    compare("unmapped_wr_err", 32'd1, {31'd0, err});

    // Corner pairs, then random pairs, each through all four operations
    for (int i = 0; i < 24; i++) begin
      if (i < 16) begin
        a = corners[i / 4];
        b = corners[i % 4];
      end else begin
        a = $urandom;
        b = $urandom;
      end
      run_op("mul", MUL_M32, 2'b00, a, b);
      run_op("mulh", MUL_H, 2'b11, a, b);
      run_op("mulhsu", MUL_H, 2'b01, a, b);
      run_op("mulhu", MUL_H, 2'b00, a, b);
    end

    // CTRL write during a MULH is refused
    a = $urandom;
    b = $urandom;
    load_operands(a, b);
    ctrl_write(MUL_H, 2'b11, 1'b1, err);
    ctrl_write(MUL_M32, 2'b00, 1'b0, err);
    compare("busy_refuse_err", 32'd1, {31'd0, err});
    wait_full("busy_refuse");
    apb_access(1'b0, `MUL_REG_RESULT, '0, rdata, err);
    compare("busy_refuse_result", product_ref(MUL_H, 2'b11, a, b), rdata);

    // Second launch while the first result sits unread
    a  = $urandom;
    b  = $urandom;
    a2 = $urandom;
    b2 = $urandom;
    load_operands(a, b);
    ctrl_write(MUL_M32, 2'b00, 1'b1, err);
    wait_full("bp_first");
    load_operands(a2, b2);
    ctrl_write(MUL_H, 2'b01, 1'b0, err);
    compare("bp_launch_err", 32'd0, {31'd0, err});
    apb_access(1'b0, `MUL_REG_STATUS, '0, rdata, err);
    compare("bp_status", 32'd3, rdata);
    apb_access(1'b0, `MUL_REG_RESULT, '0, rdata, err);
    compare("bp_first_result", product_ref(MUL_M32, 2'b00, a, b), rdata);
    wait_full("bp_second");
    apb_access(1'b0, `MUL_REG_RESULT, '0, rdata, err);
    compare("bp_second_result", product_ref(MUL_H, 2'b01, a2, b2), rdata);
    apb_access(1'b0, `MUL_REG_STATUS, '0, rdata, err);
    compare("bp_idle_status", 32'd0, rdata);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held low for five rising edges, released just after the last one
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- verilog/mul_top.sv
module mul_top import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,

  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o
);

  ////////////////////////////////////////
  // Register block to multiplier
  ////////////////////////////////////////

  mul_cmd_t    mul_cmd;
  logic        mul_enable;
  // Accumulator loop
  logic [31:0] mul_op_c;
  // Back-pressure from the result slot
  logic        mul_ex_ready;
  logic [31:0] mul_result;
  logic        mul_ready;

  mul_apb_regs u_mul_apb_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .cmd_o      (mul_cmd),
    .enable_o   (mul_enable),
    .op_c_o     (mul_op_c),
    .ex_ready_o (mul_ex_ready),
    .result_i   (mul_result),
    .ready_i    (mul_ready)
  );

  mul_unit u_mul_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mul_enable),
    .cmd_i      (mul_cmd),
    .op_c_i     (mul_op_c),
    .result_o   (mul_result),
    .ready_o    (mul_ready),
    .ex_ready_i (mul_ex_ready)
  );

endmodule

//--- verilog/mul_apb_regs.sv
`include "mul_settings.svh"

module mul_apb_regs import mul_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Software side
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,

  // Multiplier side
  output mul_cmd_t    cmd_o,
  output logic        enable_o,
  output logic [31:0] op_c_o,
  output logic        ex_ready_o,
  input  logic [31:0] result_i,
  input  logic        ready_i
);

  // Decoded access
  logic        access;
  logic        wr_en;
  logic        rd_en;
  logic        addr_hit;
  logic        ctrl_wr;
  logic        launch;
  logic        refuse;
  logic        capture;
  logic        rd_result;
  logic [31:0] rd_data;

  // Operand staging, copied into the command on launch
  logic [31:0] op_a_q;
  logic [31:0] op_b_q;
  mul_cmd_t    cmd_q;

  // MAC loop and result slot
  logic [31:0] acc_q;
  logic [31:0] result_q;
  logic        busy_q;
  logic        full_q;

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////

  // Zero wait states, everything happens in the access phase
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;
  assign rd_en  = access & ~apb_req_i.pwrite;

  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (apb_req_i.paddr)
      `MUL_REG_OP_A:   rd_data = op_a_q;
      `MUL_REG_OP_B:   rd_data = op_b_q;
      `MUL_REG_CTRL:   rd_data = {29'd0, cmd_q.short_signed, cmd_q.opcode};
      `MUL_REG_STATUS: rd_data = {30'd0, full_q, busy_q};
      `MUL_REG_RESULT: rd_data = result_q;
      // Unmapped, reads as zero
      default:         addr_hit = 1'b0;
    endcase
  end

  assign ctrl_wr   = wr_en & (apb_req_i.paddr == `MUL_REG_CTRL);
  // Only one operation in flight, the accumulator is shared
  assign launch    = ctrl_wr & ~busy_q;
  assign refuse    = ctrl_wr & busy_q;
  assign rd_result = rd_en & (apb_req_i.paddr == `MUL_REG_RESULT);

  assign apb_rsp_o.prdata  = rd_en ? rd_data : '0;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & (~addr_hit | refuse);

  ////////////////////////////////////////
  // Handshake with the multiplier
  ////////////////////////////////////////

  // Result accepted when the slot is free
  assign capture = busy_q & ready_i & ~full_q;

  assign cmd_o      = cmd_q;
  assign enable_o   = busy_q;
  assign op_c_o     = acc_q;
  assign ex_ready_o = ~full_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      full_q   <= 1'b0;
      cmd_q    <= '0;
      result_q <= '0;
    end else begin
      if (launch) begin
        busy_q             <= 1'b1;
        cmd_q.opcode       <= mul_opcode_e'(apb_req_i.pwdata[0]);
        cmd_q.short_signed <= apb_req_i.pwdata[2:1];
        cmd_q.op_a         <= op_a_q;
        cmd_q.op_b         <= op_b_q;
      end else if (capture) begin
        busy_q <= 1'b0;
      end

      // Capture wins over a read on the same edge
      if (capture) begin
        full_q   <= 1'b1;
        result_q <= result_i;
      end else if (rd_result) begin
        full_q <= 1'b0;
      end
    end
  end

  // Operands may be restaged while an operation runs
  always_ff @(posedge clk) begin
    if (wr_en && (apb_req_i.paddr == `MUL_REG_OP_A)) begin
      op_a_q <= apb_req_i.pwdata;
    end
    if (wr_en && (apb_req_i.paddr == `MUL_REG_OP_B)) begin
      op_b_q <= apb_req_i.pwdata;
    end

    // Partial sums feed back while the multiplier is stepping
    // Hold once it presents a final result, it may wait on the slot
    if (launch) begin
      acc_q <= '0;
    end else if (busy_q && !ready_i) begin
      acc_q <= result_i;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Unread result is never overwritten
  a_slot_kept: assert property (@(posedge clk) disable iff (!rst_n)
    full_q |=> $stable(result_q));

  // No second launch while busy, refused CTRL writes change nothing
  a_cmd_kept: assert property (@(posedge clk) disable iff (!rst_n)
    busy_q |=> $stable(cmd_q));

endmodule

//--- verilog/mul_unit.sv
module mul_unit import mul_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Operation launch
  input  logic        enable_i,
  input  mul_cmd_t    cmd_i,
  // Running accumulator fed back by the register block
  input  logic [31:0] op_c_i,

  output logic [31:0] result_o,
  output logic        ready_o,
  input  logic        ex_ready_i
);

  ////////////////////////////////////////
  // Subword MAC datapath
  ////////////////////////////////////////

  // 17 bit operands, top bit is the optional sign extension
  logic [16:0] sub_a;
  logic [16:0] sub_b;
  // Accumulator with the saved carry on top
  logic [32:0] sub_c;
  logic [33:0] sub_prod;
  logic [33:0] sub_mac;
  // MAC sum with upper bits kept only for arithmetic steps
  logic [33:0] sub_ext;
  logic [31:0] sub_res;

  // Low word of the full product
  logic [31:0] low_prod;

  // Step controls from the sequencer
  mult_state_e state_q;
  mult_state_e state_d;
  // Bit 0 picks the high half of A, bit 1 the high half of B
  logic [1:0]  sel_hi;
  // Bit 0 sign extends A, bit 1 sign extends B
  logic [1:0]  ext_sign;
  logic        shift16;
  logic        arith;
  logic        carry_save;
  logic        carry_q;
  logic        stall;

  // Subword selection
  assign sub_a[15:0] = sel_hi[0] ? cmd_i.op_a[31:16] : cmd_i.op_a[15:0];
  assign sub_b[15:0] = sel_hi[1] ? cmd_i.op_b[31:16] : cmd_i.op_b[15:0];

  // Sign bit only when that operand half is a signed high half
  assign sub_a[16] = ext_sign[0] & sub_a[15];
  assign sub_b[16] = ext_sign[1] & sub_b[15];

  assign sub_c = {carry_q, op_c_i};

  // 17x17 signed product always fits in 34 bits
  assign sub_prod = $signed(sub_a) * $signed(sub_b);
  assign sub_mac  = $signed(sub_c) + $signed(sub_prod);

  // Unsigned first step drops the two top bits
  assign sub_ext = {arith & sub_mac[33], arith & sub_mac[32], sub_mac[31:0]};

  // Arithmetic shift right by 16 when moving up one subword
  assign sub_res = shift16 ? {{14{sub_ext[33]}}, sub_ext[33:16]} : sub_ext[31:0];

  ////////////////////////////////////////
  // MULH sequencer
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    sel_hi     = 2'b00;
    ext_sign   = 2'b00;
    shift16    = 1'b0;
    arith      = 1'b0;
    carry_save = 1'b0;
    stall      = 1'b0;

    case (state_q)
      ALBL: begin
        // Both low halves are unsigned
        if (enable_i && (cmd_i.opcode == MUL_H)) begin
          stall   = 1'b1;
          shift16 = 1'b1;
          state_d = ALBH;
        end
      end

      ALBH: begin
        // B high half carries the sign of B
        stall      = 1'b1;
        sel_hi     = 2'b10;
        ext_sign   = {cmd_i.short_signed[1], 1'b0};
        arith      = 1'b1;
        // 33 bit sum, keep bit 32 for the next step
        carry_save = 1'b1;
        state_d    = AHBL;
      end

      AHBL: begin
        // A high half carries the sign of A
        stall    = 1'b1;
        sel_hi   = 2'b01;
        ext_sign = {1'b0, cmd_i.short_signed[0]};
        arith    = 1'b1;
        shift16  = 1'b1;
        state_d  = AHBH;
      end

      AHBH: begin
        sel_hi   = 2'b11;
        ext_sign = cmd_i.short_signed;
        // Hold the final sum until the result slot can take it
        if (ex_ready_i) begin
          state_d = ALBL;
        end
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Carry lives for exactly one step, ALBH into AHBL
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALBL;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      carry_q <= carry_save & sub_mac[32];
    end
  end

  ////////////////////////////////////////
  // Result selection
  ////////////////////////////////////////

  // Low word does not depend on operand signedness
  assign low_prod = cmd_i.op_a * cmd_i.op_b;

  assign result_o = (cmd_i.opcode == MUL_M32) ? low_prod : sub_res;

  // MUL is single cycle, MULH only valid once in AHBH
  assign ready_o = !stall;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Final sum must not be dropped while the slot is blocked
  a_ahbh_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == AHBH && !ex_ready_i) |=> (state_q == AHBH));

  // Partial sums in the middle steps are never presented as a result
  a_mid_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q inside {ALBH, AHBL}) |-> !ready_o);

endmodule

//--- verilog/mul_pkg.sv
`include "mul_settings.svh"

package mul_pkg;

  ////////////////////////////////////////
  // Multiplier encodings
  ////////////////////////////////////////

  // Low word or high word of the product
  typedef enum logic [0:0] {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_opcode_e;

  // Partial product currently in the 17x17 MAC
  typedef enum logic [1:0] {
    ALBL = 2'd0,
    ALBH = 2'd1,
    AHBL = 2'd2,
    AHBH = 2'd3
  } mult_state_e;

  // Operation handed to the multiplier
  // short_signed bit 0 marks A signed, bit 1 marks B signed
  typedef struct packed {
    mul_opcode_e opcode;
    logic [1:0]  short_signed;
    logic [31:0] op_a;
    logic [31:0] op_b;
  } mul_cmd_t;

  ////////////////////////////////////////
  // APB
  ////////////////////////////////////////

  typedef struct packed {
    logic [`MUL_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

//--- verilog/mul_settings.svh
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

////////////////////////////////////////
// APB address space
////////////////////////////////////////

// Byte address width of the register window
`define MUL_ADDR_W 5

// Register offsets, word aligned
`define MUL_REG_OP_A   5'h00
`define MUL_REG_OP_B   5'h04
// Bit 0 opcode, bits 2:1 operand signedness
`define MUL_REG_CTRL   5'h08
// Bit 0 busy, bit 1 result slot full
`define MUL_REG_STATUS 5'h0C
// Reading clears the full flag
`define MUL_REG_RESULT 5'h10

`endif
